//--- fadd_h.f
+incdir+include
rtl/fadd_ctrl_pkg.sv
rtl/fadd_fmt_pkg.sv
rtl/fadd_if.sv
rtl/fadd_pipe_reg.sv
rtl/fadd_close_s0.sv
rtl/fadd_far_s0.sv
rtl/fadd_s0.sv
rtl/fadd_s1.sv
rtl/fadd_h.sv
tb/fadd_h_sva.sv
tb/fadd_h_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := fadd_h_tb
FLIST     := fadd_h.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 -Mdir $(OBJ_DIR)
RUN_FLAGS := +verilator+error+limit+100

SRCS := $(wildcard rtl/*.sv tb/*.sv include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)

//--- tb/fadd_h_tb.sv
/*
  Testbench for the binary16 adder. Results are checked by the bound checker.
  Operands come from a 16-bit LFSR with a fixed seed, shaped per phase.
*/
`timescale 1ns/1ps

module fadd_h_tb;

  logic        forever_cpuclk;
  logic        arst_n;
  logic        in_valid;
  logic [15:0] in_a;
  logic [15:0] in_b;
  logic        in_sub;
  logic        out_valid;
  logic [15:0] out_res;
  logic [2:0]  out_flags;
  logic [15:0] lfsr_q;

  fadd_h fadd_h_inst (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .in_valid       (in_valid),
    .in_a           (in_a),
    .in_b           (in_b),
    .in_sub         (in_sub),
    .out_valid      (out_valid),
    .out_res        (out_res),
    .out_flags      (out_flags)
  );

  always #50 forever_cpuclk = ~forever_cpuclk;

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[14:0], fb};
    end
    return v;
  endfunction

  function automatic logic [15:0] rand_normal();
    logic       s;
    logic [4:0] e;
    logic [9:0] f;
    s = 1'(take_bits(1));
    e = 5'(take_bits(5));
    f = 10'(take_bits(10));
    if (e == 5'd0) e = 5'd1;
    if (e == 5'd31) e = 5'd30;
    return {s, e, f};
  endfunction

  function automatic logic [4:0] clamp_exp(input int e);
    if (e < 1) return 5'd1;
    if (e > 30) return 5'd30;
    return 5'(e);
  endfunction

  task automatic issue(input logic [15:0] a, input logic [15:0] b, input logic sub);
    @(posedge forever_cpuclk);
    in_valid <= 1'b1;
    in_a     <= a;
    in_b     <= b;
    in_sub   <= sub;
  endtask

  task automatic wait_valid(input logic level, input string phase);
    int cnt;
    cnt = 0;
    @(negedge forever_cpuclk);
    while (out_valid !== level) begin
      if (cnt >= 8) begin
        $display("Timeout: out_valid did not become %0b in phase %s", level, phase);
        $display("CHECKS FAILED");
        $fatal(1, "out_valid timeout");
      end
      @(negedge forever_cpuclk);
      cnt++;
    end
  endtask

  // Stop issuing and let the pipeline drain
  task automatic end_phase(input string phase);
    @(posedge forever_cpuclk);
    in_valid <= 1'b0;
    wait_valid(1'b1, phase);
    wait_valid(1'b0, phase);
  endtask

  task automatic special_round();
    logic [15:0] x;
    logic [15:0] y;
    logic [9:0]  f;
    logic        s;
    x = rand_normal();
    s = 1'(take_bits(1));
    f = 10'(take_bits(10));
    if (f == 10'd0) f = 10'd1;
    // NaN on either side, quiet or signaling by f[9]
    issue({s, 5'h1F, f}, x, s);
    issue(x, {~s, 5'h1F, f}, ~s);
    // Opposite infinities, then like infinities
    issue(16'h7C00, {s, 15'h7C00}, ~s);
    issue(16'h7C00, {s, 15'h7C00}, s);
    issue({s, 15'h7C00}, x, s);
    issue(x, {s, 15'h7C00}, ~s);
    // Signed zero on either side
    issue(x, {s, 15'h0000}, ~s);
    issue({s, 15'h0000}, x, s);
    // Largest finite plus at least half an ulp
    y = rand_normal();
    y[14:10] = 5'd19 + (y[14:10] % 5'd12);
    issue({s, 15'h7BFF}, y, y[15] ^ s);
    // One plus a value below a quarter ulp
    y = rand_normal();
    y[14:10] = 5'd1 + 5'(y[0]);
    issue(16'h3C00, y, y[15]);
  endtask

  always @(posedge forever_cpuclk) begin
    if (fadd_h_inst.u_sva.fail_cnt != 0) begin
      $display("CHECKS FAILED");
      $fatal(1, "checker assertion failed");
    end
  end

  initial begin
    logic [15:0] a;
    logic [15:0] b;
    logic        s;
    logic [1:0]  d;
    int          e;
    forever_cpuclk = 1'b0;
    arst_n         = 1'b0;
    in_valid       = 1'b0;
    in_a           = 16'd0;
    in_b           = 16'd0;
    in_sub         = 1'b0;
    lfsr_q         = 16'd55363;
    repeat (5) @(posedge forever_cpuclk);
    arst_n <= 1'b1;
    @(posedge forever_cpuclk);

    for (int i = 0; i < 200; i++) begin
      a = rand_normal();
      b = rand_normal();
      s = 1'(take_bits(1));
      issue(a, b, s);
    end
    end_phase("random");

    // Exponents within one, effective subtraction
    for (int i = 0; i < 400; i++) begin
      a = rand_normal();
      s = 1'(take_bits(1));
      d = 2'(take_bits(2));
      e = int'(a[14:10]) + ((d == 2'd0) ? -1 : ((d == 2'd1) ? 1 : 0));
      b = {~a[15] ^ s, clamp_exp(e), 10'(take_bits(10))};
      issue(a, b, s);
    end
    end_phase("close");

    for (int i = 0; i < 50; i++) begin
      a = rand_normal();
      s = 1'(take_bits(1));
      issue(a, {~a[15] ^ s, a[14:0]}, s);
    end
    end_phase("equal");

    for (int i = 0; i < 20; i++) begin
      special_round();
    end
    end_phase("special");

    repeat (3) @(posedge forever_cpuclk);
    if (fadd_h_inst.u_sva.fail_cnt != 0) begin
      $display("CHECKS FAILED");
      $fatal(1, "checker reported failures");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

//--- tb/fadd_h_sva.sv
/*
  Bound checker for the binary16 adder. Keeps its own 2-cycle input history.
  Reference results are computed from the operand fields with integer arithmetic.
  Only normal operands are checked on the close path.
*/
`timescale 1ns/1ps
`include "fadd_cfg.svh"

module fadd_h_sva (
  input logic        forever_cpuclk,
  input logic        arst_n,
  input logic        in_valid,
  input logic [15:0] in_a,
  input logic [15:0] in_b,
  input logic        in_sub,
  input logic        out_valid,
  input logic [15:0] out_res,
  input logic [2:0]  out_flags
);

  logic        v_d1, v_d2;
  logic [15:0] a_d1, a_d2, b_d1, b_d2;
  logic        s_d1, s_d2;
  logic        es;
  logic        cancel_c, close_c, ident_c, nan_c, inf_c, ovf_c, tiny_c;
  logic        nan_inv;
  logic [18:0] got, close_exp, ident_exp, nan_exp, inf_exp, ovf_exp;
  int          fail_cnt = 0;

  function automatic logic is_norm(input logic [15:0] x);
    return (x[14:10] != 5'd0) && (x[14:10] != 5'(`FADD_EXP_MAX));
  endfunction

  function automatic logic is_nan(input logic [15:0] x);
    return (x[14:10] == 5'(`FADD_EXP_MAX)) && (x[9:0] != 10'd0);
  endfunction

  function automatic logic is_inf(input logic [15:0] x);
    return (x[14:10] == 5'(`FADD_EXP_MAX)) && (x[9:0] == 10'd0);
  endfunction

  function automatic logic exp_near(input logic [15:0] a, input logic [15:0] b);
    int d;
    d = int'(a[14:10]) - int'(b[14:10]);
    return (d >= -1) && (d <= 1);
  endfunction

  // Exact difference on a common scale, then renormalized
  function automatic logic [18:0] close_ref(input logic [15:0] a, input logic [15:0] b,
                                            input logic sub);
    int   ea, eb, emin, ma, mb, diff, p, e, kept, g;
    logic sign;
    ea   = int'(a[14:10]);
    eb   = int'(b[14:10]);
    emin = (ea < eb) ? ea : eb;
    ma   = ((1 << `FADD_MAN_W) + int'(a[9:0])) << (ea - emin);
    mb   = ((1 << `FADD_MAN_W) + int'(b[9:0])) << (eb - emin);
    sign = (ma > mb) ? a[15] : (b[15] ^ sub);
    diff = (ma > mb) ? (ma - mb) : (mb - ma);
    p    = 0;
    for (int i = 0; i < 12; i++) begin
      if (diff[i]) p = i;
    end
    e = p + emin - `FADD_MAN_W;
    g = 0;
    // One bit beyond the significand, a tie goes to even
    if (p == 11) begin
      g    = diff & 1;
      kept = (diff >> 1) + (g & (diff >> 1) & 1);
    end else begin
      kept = diff << (`FADD_MAN_W - p);
    end
    if (e <= 0) return {sign, 15'd0, 3'b001};
    return {sign, 5'(e), 10'(kept), 2'b00, 1'(g)};
  endfunction

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      v_d1 <= 1'b0;
      v_d2 <= 1'b0;
    end else begin
      v_d1 <= in_valid;
      v_d2 <= v_d1;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    a_d1 <= in_a;
    a_d2 <= a_d1;
    b_d1 <= in_b;
    b_d2 <= b_d1;
    s_d1 <= in_sub;
    s_d2 <= s_d1;
  end

  assign es  = a_d2[15] ^ b_d2[15] ^ s_d2;
  assign got = {out_res, out_flags};

  assign cancel_c = is_norm(a_d2) && is_norm(b_d2) && es && (a_d2[14:0] == b_d2[14:0]);
  assign close_c  = is_norm(a_d2) && is_norm(b_d2) && es && exp_near(a_d2, b_d2) &&
                    (a_d2[14:0] != b_d2[14:0]);
  assign ident_c  = (is_norm(a_d2) && (b_d2[14:0] == 15'd0)) ||
                    (is_norm(b_d2) && (a_d2[14:0] == 15'd0));
  assign nan_c    = is_nan(a_d2) || is_nan(b_d2) || (is_inf(a_d2) && is_inf(b_d2) && es);
  assign inf_c    = !nan_c && (is_inf(a_d2) || is_inf(b_d2));
  assign ovf_c    = (a_d2[14:0] == 15'h7BFF) && is_norm(b_d2) && (b_d2[14:10] >= 5'd19) && !es;
  assign tiny_c   = (a_d2 == 16'h3C00) && is_norm(b_d2) && (b_d2[14:10] <= 5'd2) && !es;

  // Signaling NaN has the quiet bit clear
  assign nan_inv = (is_nan(a_d2) && !a_d2[9]) || (is_nan(b_d2) && !b_d2[9]) ||
                   (is_inf(a_d2) && is_inf(b_d2) && es);

  assign close_exp = close_ref(a_d2, b_d2, s_d2);
  assign ident_exp = is_norm(a_d2) ? {a_d2, 3'b000} : {b_d2[15] ^ s_d2, b_d2[14:0], 3'b000};
  assign nan_exp   = {`FADD_QNAN, nan_inv, 2'b00};
  assign inf_exp   = {is_inf(a_d2) ? a_d2[15] : (b_d2[15] ^ s_d2), 15'h7C00, 3'b000};
  assign ovf_exp   = {a_d2[15], 15'h7C00, 3'b011};

  a_reset: assert property (@(posedge forever_cpuclk) !arst_n |-> !out_valid)
    else begin
      fail_cnt++;
      $error("ERROR reset expected 0 actual %0b", $sampled(out_valid));
    end

  a_latency: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    out_valid == v_d2)
    else begin
      fail_cnt++;
      $error("ERROR latency expected %0b actual %0b", $sampled(v_d2), $sampled(out_valid));
    end

  a_cancel: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    out_valid && cancel_c |-> got == 19'd0)
    else begin
      fail_cnt++;
      $error("ERROR cancel expected %h actual %h", 19'd0, $sampled(got));
    end

  a_close: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    out_valid && close_c |-> got == close_exp)
    else begin
      fail_cnt++;
      $error("ERROR close expected %h actual %h", $sampled(close_exp), $sampled(got));
    end

  a_identity: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    out_valid && ident_c |-> got == ident_exp)
    else begin
      fail_cnt++;
      $error("ERROR identity expected %h actual %h", $sampled(ident_exp), $sampled(got));
    end

  a_nan: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    out_valid && nan_c |-> got == nan_exp)
    else begin
      fail_cnt++;
      $error("ERROR nan expected %h actual %h", $sampled(nan_exp), $sampled(got));
    end

  a_inf: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    out_valid && inf_c |-> got == inf_exp)
    else begin
      fail_cnt++;
      $error("ERROR inf expected %h actual %h", $sampled(inf_exp), $sampled(got));
    end

  a_overflow: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    out_valid && ovf_c |-> got == ovf_exp)
    else begin
      fail_cnt++;
      $error("ERROR overflow expected %h actual %h", $sampled(ovf_exp), $sampled(got));
    end

  a_tiny: assert property (@(posedge forever_cpuclk) disable iff (!arst_n)
    out_valid && tiny_c |-> got == {16'h3C00, 3'b001})
    else begin
      fail_cnt++;
      $error("ERROR tiny expected %h actual %h", {16'h3C00, 3'b001}, $sampled(got));
    end

endmodule

bind fadd_h fadd_h_sva u_sva (
  .forever_cpuclk (forever_cpuclk),
  .arst_n         (arst_n),
  .in_valid       (in_valid),
  .in_a           (in_a),
  .in_b           (in_b),
  .in_sub         (in_sub),
  .out_valid      (out_valid),
  .out_res        (out_res),
  .out_flags      (out_flags)
);

//--- rtl/fadd_h.sv
/*
  Binary16 adder and subtractor, round to nearest even, fixed 2-cycle latency.
  One operation per cycle, no back-pressure. Subnormals are treated as zero.
  out_flags is {invalid, overflow, inexact}.
*/
`timescale 1ns/1ps

module fadd_h (
  input  logic        forever_cpuclk,
  input  logic        arst_n,
  input  logic        in_valid,
  input  logic [15:0] in_a,
  input  logic [15:0] in_b,
  input  logic        in_sub,
  output logic        out_valid,
  output logic [15:0] out_res,
  output logic [2:0]  out_flags
);

  fadd_if s0_s1_if ();

  fadd_s0 u_s0 (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .in_valid       (in_valid),
    .in_a           (in_a),
    .in_b           (in_b),
    .in_sub         (in_sub),
    .s1             (s0_s1_if.src)
  );

  fadd_s1 u_s1 (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .s0             (s0_s1_if.dst),
    .out_valid      (out_valid),
    .out_res        (out_res),
    .out_flags      (out_flags)
  );

endmodule

//--- rtl/fadd_s1.sv
/*
  Stage 1: normalize, round to nearest even, pack, flags, one register stage.
  Tiny results flush to signed zero with inexact set. NaN results are always 7E00.
*/
`timescale 1ns/1ps
`include "fadd_cfg.svh"

module fadd_s1 import fadd_fmt_pkg::*, fadd_ctrl_pkg::*; (
  input  logic        forever_cpuclk,
  input  logic        arst_n,
  fadd_if.dst         s0,
  output logic        out_valid,
  output fp16_t       out_res,
  output fadd_flags_t out_flags
);

  sig_t               c_sh0, c_sh;
  logic [4:0]         kc0, kc;
  logic [11:0]        n12_0, n12;
  sig_t               sig;
  logic               g, s;
  logic               rnd_up;
  logic [11:0]        sig_rnd;
  logic signed [7:0]  e_pre, e_rnd;
  fp16_t              res;
  fadd_flags_t        flags;
  res_t               res_d, res_q;

  // Close path: predicted shift, then one-bit correction
  always_comb begin
    c_sh0 = s0.close_sum << s0.ff1_pred;
    if (!c_sh0[10]) begin
      c_sh = c_sh0 << 1;
      kc0  = {1'b0, s0.ff1_pred} + 5'd1;
    end else begin
      c_sh = c_sh0;
      kc0  = {1'b0, s0.ff1_pred};
    end
    // Put back the half-ulp dropped by the pre-shift
    n12_0 = {c_sh, 1'b0} - (12'(s0.far_sum[0]) << kc0);
    if (!n12_0[11]) begin
      n12 = n12_0 << 1;
      kc  = kc0 + 5'd1;
    end else begin
      n12 = n12_0;
      kc  = kc0;
    end
  end

  always_comb begin
    if (s0.path == fadd_path_close) begin
      sig   = n12[11:1];
      g     = n12[0];
      s     = 1'b0;
      e_pre = 8'(s0.exp) - 8'(kc);
    end else if (s0.far_sum[13]) begin
      sig   = s0.far_sum[13:3];
      g     = s0.far_sum[2];
      s     = |s0.far_sum[1:0];
      e_pre = 8'(s0.exp);
    end else begin
      sig   = s0.far_sum[12:2];
      g     = s0.far_sum[1];
      s     = s0.far_sum[0];
      e_pre = 8'(s0.exp) - 8'sd1;
    end
  end

  assign rnd_up  = g & (s | sig[0]);
  assign sig_rnd = {1'b0, sig} + 12'(rnd_up);
  assign e_rnd   = e_pre + 8'(sig_rnd[11]);

  always_comb begin
    res           = {s0.sign, e_rnd[`FADD_EXP_W-1:0], sig_rnd[`FADD_MAN_W-1:0]};
    flags         = '0;
    flags.inexact = g | s;
    if (e_rnd >= 8'sd`FADD_EXP_MAX) begin
      res            = {s0.sign, `FADD_EXP_W'(`FADD_EXP_MAX), `FADD_MAN_W'(0)};
      flags.overflow = 1'b1;
      flags.inexact  = 1'b1;
    end else if (e_rnd <= 8'sd0) begin
      res           = {s0.sign, 15'd0};
      flags.inexact = 1'b1;
    end
    case (s0.special)
      fadd_spc_nan: begin
        res   = `FADD_QNAN;
        flags = '{invalid: s0.sign, overflow: 1'b0, inexact: 1'b0};
      end
      fadd_spc_inf: begin
        res   = {s0.sign, `FADD_EXP_W'(`FADD_EXP_MAX), `FADD_MAN_W'(0)};
        flags = '0;
      end
      fadd_spc_zero: begin
        res   = {s0.sign, 15'd0};
        flags = '0;
      end
      default: begin
        // Exact cancellation is +0
        if (s0.path == fadd_path_close && s0.eq) begin
          res   = '0;
          flags = '0;
        end
      end
    endcase
  end

  assign res_d.res   = res;
  assign res_d.flags = flags;

  fadd_pipe_reg #(.payload_t(res_t)) u_reg (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .in_valid       (s0.valid),
    .in_pay         (res_d),
    .out_valid      (out_valid),
    .out_pay        (res_q)
  );

  assign out_res   = res_q.res;
  assign out_flags = res_q.flags;

endmodule

//--- rtl/fadd_s0.sv
/*
  Stage 0: unpack, classify, pick close or far path, one register stage.
  Subnormal inputs are read as zero. Signaling NaNs and inf-inf mark invalid.
*/
`timescale 1ns/1ps
`include "fadd_cfg.svh"

module fadd_s0 import fadd_fmt_pkg::*, fadd_ctrl_pkg::*; (
  input  logic  forever_cpuclk,
  input  logic  arst_n,
  input  logic  in_valid,
  input  fp16_t in_a,
  input  fp16_t in_b,
  input  logic  in_sub,
  fadd_if.src   s1
);

  logic                   b_sign;
  logic                   eff_sub;
  logic                   a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
  logic                   invalid;
  sig_t                   a_sig, b_sig;
  logic                   a_big;
  logic                   big_sign, small_sign;
  sig_t                   big_sig, small_sig;
  logic [`FADD_EXP_W-1:0] big_exp, exp_diff;
  logic                   close_sel;
  sig_t                   close_adder1;
  logic                   close_eq, close_op_chg;
  sig_t                   close_sum;
  logic [3:0]             ff1_pred;
  logic [13:0]            far_sum;
  s0_pay_t                pay, pay_q;
  logic                   valid_q;

  assign b_sign  = in_b.sign ^ in_sub;
  assign eff_sub = in_a.sign ^ b_sign;

  assign a_zero = (in_a.exp == '0);
  assign b_zero = (in_b.exp == '0);
  assign a_inf  = (in_a.exp == `FADD_EXP_W'(`FADD_EXP_MAX)) && (in_a.frac == '0);
  assign b_inf  = (in_b.exp == `FADD_EXP_W'(`FADD_EXP_MAX)) && (in_b.frac == '0);
  assign a_nan  = (in_a.exp == `FADD_EXP_W'(`FADD_EXP_MAX)) && (in_a.frac != '0);
  assign b_nan  = (in_b.exp == `FADD_EXP_W'(`FADD_EXP_MAX)) && (in_b.frac != '0);
  // Quiet bit clear means signaling
  assign invalid = (a_nan & ~in_a.frac[`FADD_MAN_W-1]) | (b_nan & ~in_b.frac[`FADD_MAN_W-1]) |
                   (a_inf & b_inf & eff_sub);

  assign a_sig = a_zero ? '0 : {1'b1, in_a.frac};
  assign b_sig = b_zero ? '0 : {1'b1, in_b.frac};

  // Order by exponent only; close path resolves equal exponents itself
  assign a_big      = (in_a.exp >= in_b.exp);
  assign big_sig    = a_big ? a_sig : b_sig;
  assign small_sig  = a_big ? b_sig : a_sig;
  assign big_sign   = a_big ? in_a.sign : b_sign;
  assign small_sign = a_big ? b_sign : in_a.sign;
  assign big_exp    = a_big ? in_a.exp : in_b.exp;
  assign exp_diff   = a_big ? (in_a.exp - in_b.exp) : (in_b.exp - in_a.exp);

  assign close_sel    = eff_sub & (exp_diff <= `FADD_EXP_W'(1));
  assign close_adder1 = exp_diff[0] ? (small_sig >> 1) : small_sig;

  fadd_close_s0 u_close (
    .close_adder0    (big_sig),
    .close_adder1    (close_adder1),
    .close_eq        (close_eq),
    .close_op_chg    (close_op_chg),
    .close_sum       (close_sum),
    .ff1_pred        (ff1_pred),
    .ff1_pred_onehot ()
  );

  fadd_far_s0 u_far (
    .big_sig   (big_sig),
    .small_sig (small_sig),
    .shift     (exp_diff),
    .sub       (eff_sub),
    .far_sum   (far_sum)
  );

  always_comb begin
    pay           = '0;
    pay.path      = close_sel ? fadd_path_close : fadd_path_far;
    pay.close_sum = close_sum;
    pay.ff1_pred  = ff1_pred;
    pay.eq        = close_eq;
    // Additions sit one position lower in the far frame
    pay.exp       = close_sel ? big_exp : big_exp + {{(`FADD_EXP_W-1){1'b0}}, ~eff_sub};
    pay.far_sum   = close_sel ? {13'd0, exp_diff[0] & small_sig[0]} : far_sum;
    if (a_nan | b_nan | (a_inf & b_inf & eff_sub)) begin
      pay.special = fadd_spc_nan;
      pay.sign    = invalid;
    end else if (a_inf | b_inf) begin
      pay.special = fadd_spc_inf;
      pay.sign    = a_inf ? in_a.sign : b_sign;
    end else if (a_zero & b_zero) begin
      pay.special = fadd_spc_zero;
      pay.sign    = in_a.sign & b_sign;
    end else begin
      pay.special = fadd_spc_none;
      if (close_sel) begin
        pay.sign = ~close_eq & (close_op_chg ? small_sign : big_sign);
      end else begin
        pay.sign = big_sign;
      end
    end
  end

  fadd_pipe_reg #(.payload_t(s0_pay_t)) u_reg (
    .forever_cpuclk (forever_cpuclk),
    .arst_n         (arst_n),
    .in_valid       (in_valid),
    .in_pay         (pay),
    .out_valid      (valid_q),
    .out_pay        (pay_q)
  );

  assign s1.valid     = valid_q;
  assign s1.sign      = pay_q.sign;
  assign s1.exp       = pay_q.exp;
  assign s1.path      = pay_q.path;
  assign s1.close_sum = pay_q.close_sum;
  assign s1.ff1_pred  = pay_q.ff1_pred;
  assign s1.far_sum   = pay_q.far_sum;
  assign s1.special   = pay_q.special;
  assign s1.eq        = pay_q.eq;

endmodule

//--- rtl/fadd_far_s0.sv
/*
  Far-path alignment and add or subtract. Output frame is 14 bits.
  Add: carry, significand, guard, round|sticky. Subtract: significand, guard, round, sticky.
  The caller offsets the exponent by one for additions so both frames share a scale.
*/
`timescale 1ns/1ps

module fadd_far_s0 import fadd_fmt_pkg::*; (
  input  sig_t        big_sig,
  input  sig_t        small_sig,
  input  logic [4:0]  shift,
  input  logic        sub,
  output logic [13:0] far_sum
);

  logic [5:0]  sh_amt;
  logic [27:0] sm_wide;
  logic [13:0] sm_al;
  logic        sticky;
  logic [13:0] big_f;
  logic [13:0] small_f;

  // Beyond 14 everything lands in the sticky bit anyway
  assign sh_amt = ((shift > 5'd14) ? 6'd14 : {1'b0, shift}) + {5'd0, ~sub};

  assign sm_wide = {small_sig, 3'b000, 14'd0} >> sh_amt;
  assign sm_al   = sm_wide[27:14];
  assign sticky  = |sm_wide[13:0];

  assign small_f = {sm_al[13:1], sm_al[0] | sticky};
  assign big_f   = sub ? {big_sig, 3'b000} : {1'b0, big_sig, 2'b00};

  assign far_sum = sub ? (big_f - small_f) : (big_f + small_f);

endmodule

//--- rtl/fadd_close_s0.sv
/*
  Close-path subtraction of two aligned significands, result kept non-negative.
  The leading-one prediction is exact or one position too high.
*/
`timescale 1ns/1ps

module fadd_close_s0 import fadd_fmt_pkg::*; (
  input  sig_t        close_adder0,
  input  sig_t        close_adder1,
  output logic        close_eq,
  output logic        close_op_chg,
  output sig_t        close_sum,
  output logic [3:0]  ff1_pred,
  output logic [10:0] ff1_pred_onehot
);

  logic [11:0] diff_ab;
  logic [11:0] diff_ba;
  logic [10:0] close_ff1_c;
  logic [10:0] close_ff1_t;
  logic [10:0] close_ff1_g;
  logic [10:0] close_ff1_z;
  logic [10:0] close_ff1_f;

  // Both orders, keep the one without borrow
  assign diff_ab      = {1'b0, close_adder0} - {1'b0, close_adder1};
  assign diff_ba      = {1'b0, close_adder1} - {1'b0, close_adder0};
  assign close_op_chg = diff_ab[11];
  assign close_sum    = diff_ab[11] ? diff_ba[10:0] : diff_ab[10:0];
  assign close_eq     = ~diff_ab[11] & ~diff_ba[11];

  // Predictor operates on A and inverted B
  assign close_ff1_c = ~close_adder1;
  assign close_ff1_t = close_adder0 ^ close_ff1_c;
  assign close_ff1_g = close_adder0 & close_ff1_c;
  assign close_ff1_z = ~close_adder0 & ~close_ff1_c;

  always_comb begin
    close_ff1_f[10] = (close_ff1_g[10] & ~close_ff1_z[9]) |
                      (close_ff1_z[10] & ~close_ff1_g[9]);
    close_ff1_f[0]  = close_ff1_g[0] | close_ff1_z[0];
    for (int i = 1; i < 10; i++) begin
      if (close_ff1_t[i+1]) begin
        close_ff1_f[i] = (close_ff1_g[i] & ~close_ff1_z[i-1]) |
                         (close_ff1_z[i] & ~close_ff1_g[i-1]);
      end else begin
        close_ff1_f[i] = (close_ff1_g[i] & ~close_ff1_g[i-1]) |
                         (close_ff1_z[i] & ~close_ff1_z[i-1]);
      end
    end
  end

  // Highest set bit of f wins, scanned upward
  always_comb begin
    ff1_pred        = 4'd0;
    ff1_pred_onehot = 11'd0;
    for (int i = 0; i < 11; i++) begin
      if (close_ff1_f[i]) begin
        ff1_pred        = 4'(10 - i);
        ff1_pred_onehot = 11'd1 << i;
      end
    end
  end

endmodule

//--- rtl/fadd_pipe_reg.sv
/*
  Valid-qualified pipeline register. Payload holds its value while valid is low.
  No back-pressure.
*/
`timescale 1ns/1ps

module fadd_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     forever_cpuclk,
  input  logic     arst_n,
  input  logic     in_valid,
  input  payload_t in_pay,
  output logic     out_valid,
  output payload_t out_pay
);

  always_ff @(posedge forever_cpuclk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      out_pay   <= '0;
    end else begin
      out_valid <= in_valid;
      // Only capture qualified data
      if (in_valid) begin
        out_pay <= in_pay;
      end
    end
  end

endmodule

//--- rtl/fadd_if.sv
/*
  Stage-0 to stage-1 link. Fields are valid only while valid is high.
  No ready signal; the receiver must take every beat.
*/
`timescale 1ns/1ps
`include "fadd_cfg.svh"

interface fadd_if import fadd_fmt_pkg::*, fadd_ctrl_pkg::*; ();

  logic                   valid;
  logic                   sign;
  logic [`FADD_EXP_W-1:0] exp;
  fadd_path_e             path;
  sig_t                   close_sum;
  logic [3:0]             ff1_pred;
  logic [13:0]            far_sum;
  fadd_special_e          special;
  logic                   eq;

  modport src (output valid, sign, exp, path, close_sum, ff1_pred, far_sum, special, eq);
  modport dst (input  valid, sign, exp, path, close_sum, ff1_pred, far_sum, special, eq);

endinterface

//--- rtl/fadd_fmt_pkg.sv
/*
  Number-format types: the binary16 word, the significand and the stage-0 payload.
  On the close path far_sum[0] carries the bit lost by the one-position pre-shift.
  For a NaN result the sign field carries the invalid indication.
*/
`include "fadd_cfg.svh"

package fadd_fmt_pkg;

  import fadd_ctrl_pkg::*;

  typedef struct packed {
    logic                   sign;
    logic [`FADD_EXP_W-1:0] exp;
    logic [`FADD_MAN_W-1:0] frac;
  } fp16_t;

  // Significand with hidden bit
  typedef logic [`FADD_MAN_W:0] sig_t;

  typedef struct packed {
    logic                   sign;
    logic [`FADD_EXP_W-1:0] exp;
    fadd_path_e             path;
    sig_t                   close_sum;
    logic [3:0]             ff1_pred;
    // Carry, significand, guard, round and sticky
    logic [13:0]            far_sum;
    fadd_special_e          special;
    logic                   eq;
  } s0_pay_t;

endpackage

//--- rtl/fadd_ctrl_pkg.sv
/*
  Control types of the binary16 adder: special-case class, path choice, flags.
  Only invalid, overflow and inexact are reported.
*/
`include "fadd_cfg.svh"

package fadd_ctrl_pkg;

  // Result class decided in stage 0
  typedef enum logic [1:0] {
    fadd_spc_none = 2'd0,
    fadd_spc_zero = 2'd1,
    fadd_spc_inf  = 2'd2,
    fadd_spc_nan  = 2'd3
  } fadd_special_e;

  typedef enum logic {
    fadd_path_close = 1'b0,
    fadd_path_far   = 1'b1
  } fadd_path_e;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic inexact;
  } fadd_flags_t;

  // Packed result word with its flags
  typedef struct packed {
    logic [`FADD_EXP_W+`FADD_MAN_W:0] res;
    fadd_flags_t                      flags;
  } res_t;

endpackage

//--- include/fadd_cfg.svh
/*
  Binary16 format constants shared by the packages, the pipeline stages and the checker.
  Only the IEEE half-precision layout is supported.
*/
`ifndef FADD_CFG_SVH
`define FADD_CFG_SVH

// Field widths of the stored word
`define FADD_EXP_W   5
`define FADD_MAN_W   10

// Exponent bias and the all-ones exponent of infinity and NaN
`define FADD_BIAS    15
`define FADD_EXP_MAX 31

// Canonical quiet NaN returned for every NaN result
`define FADD_QNAN    16'h7E00

`endif
